//--- clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module clk_gen (
	output logic clk
);
	// 10 ns period
	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

endmodule

`default_nettype wire

//--- dispatch_pkg.sv
`default_nettype none

package dispatch_pkg;

	localparam int XLEN = 32;
	localparam int ROB_SIZE = 8;
	localparam int ROB_TAG_WIDTH = $clog2(ROB_SIZE);
	localparam int N_ALU_RS = 4;
	localparam int N_AGU_RS = 2;
	localparam int N_BRANCH_RS = 2;

	// widest station class, used by the shared free-slot selector
	localparam int RS_VEC_WIDTH = (N_ALU_RS >= N_AGU_RS && N_ALU_RS >= N_BRANCH_RS) ? N_ALU_RS
		: (N_AGU_RS >= N_BRANCH_RS) ? N_AGU_RS : N_BRANCH_RS;

	// rv32i major opcodes handled here, zero is an inserted bubble
	typedef enum logic [6:0] {
		OP_BUBBLE = 7'b0000000,
		OP_LOAD   = 7'b0000011,
		OP_IMM    = 7'b0010011,
		OP_AUIPC  = 7'b0010111,
		OP_STORE  = 7'b0100011,
		OP_REG    = 7'b0110011,
		OP_LUI    = 7'b0110111,
		OP_BRANCH = 7'b1100011,
		OP_JALR   = 7'b1100111,
		OP_JAL    = 7'b1101111
	} opcode_e;

	// branch class covers jal, jalr and conditional branches
	typedef enum logic [1:0] {
		CLASS_ALU    = 2'b00,
		CLASS_BRANCH = 2'b01,
		CLASS_LOAD   = 2'b10,
		CLASS_STORE  = 2'b11
	} instr_class_e;

	typedef struct packed {
		opcode_e           opcode;
		instr_class_e      instr_class;
		logic              branch;
		logic              jalr;
		logic              lui;
		logic              auipc;
		logic              alloc_rob;
		logic              alloc_ldq;
		logic              alloc_stq;
		logic [XLEN-1:0]   imm;
	} decoded_t;

	// register file read results, tag means the value is still in flight
	typedef struct packed {
		logic [XLEN-1:0]          rs1_value;
		logic [ROB_TAG_WIDTH-1:0] rs1_tag;
		logic                     rs1_tag_valid;
		logic [XLEN-1:0]          rs2_value;
		logic [ROB_TAG_WIDTH-1:0] rs2_tag;
		logic                     rs2_tag_valid;
	} rf_read_t;

	// one operand, either a value or a tag to wait on
	typedef struct packed {
		logic                     q_valid;
		logic [ROB_TAG_WIDTH-1:0] q;
		logic [XLEN-1:0]          v;
	} operand_t;

	typedef struct packed {
		operand_t op1;
		operand_t op2;
	} operands_t;

	typedef struct packed {
		logic                     q1_valid;
		logic [ROB_TAG_WIDTH-1:0] q1;
		logic [XLEN-1:0]          v1;
		logic                     q2_valid;
		logic [ROB_TAG_WIDTH-1:0] q2;
		logic [XLEN-1:0]          v2;
		logic [ROB_TAG_WIDTH-1:0] rob_tag;
	} issue_t;

	typedef struct packed {
		logic                     valid;
		logic [ROB_TAG_WIDTH-1:0] tag;
		logic [XLEN-1:0]          value;
	} cdb_t;

	typedef struct packed {
		logic                     valid;
		logic [ROB_TAG_WIDTH-1:0] tag;
		logic [XLEN-1:0]          value;
	} commit_t;

	// one-hot of the lowest clear bit in busy, zero when everything is busy
	function automatic logic [RS_VEC_WIDTH-1:0] lowest_free(input logic [RS_VEC_WIDTH-1:0] busy);
		logic [RS_VEC_WIDTH-1:0] free;
		free = ~busy;
		// two's complement isolates the lowest set bit
		return free & (~free + 1'b1);
	endfunction

endpackage

`default_nettype wire

//--- dispatch_sva.sv
`timescale 1ns/1ps
`default_nettype none

module dispatch_sva (
	input logic                                clk,
	input logic                                arst_n,
	input logic                                flush,
	input logic                                stall,
	input logic                                alloc_rob,
	input logic                                alloc_ldq,
	input logic                                alloc_stq,
	input logic [dispatch_pkg::N_ALU_RS-1:0]    alu_rs_route,
	input logic [dispatch_pkg::N_AGU_RS-1:0]    agu_rs_route,
	input logic [dispatch_pkg::N_BRANCH_RS-1:0] branch_rs_route,
	input dispatch_pkg::commit_t               commit,
	input logic                                commit_ready
);
	import dispatch_pkg::*;

	logic [ROB_TAG_WIDTH-1:0] next_tag;

	// tag the next retiring entry must carry
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			next_tag <= '0;
		end else if (flush) begin
			next_tag <= '0;
		end else if (commit.valid && commit_ready) begin
			next_tag <= commit.tag + 1'b1;
		end
	end

	a_stall_no_alloc: assert property (@(posedge clk) disable iff (!arst_n)
		stall |-> !(alloc_rob || alloc_ldq || alloc_stq
		|| (|alu_rs_route) || (|agu_rs_route) || (|branch_rs_route)))
		else $error("allocation during stall");

	a_route_onehot: assert property (@(posedge clk) disable iff (!arst_n)
		$onehot0(alu_rs_route) && $onehot0(agu_rs_route) && $onehot0(branch_rs_route))
		else $error("more than one station selected");

	a_commit_order: assert property (@(posedge clk) disable iff (!arst_n)
		commit.valid |-> commit.tag == next_tag)
		else $error("commit tag out of order");

endmodule

bind dispatch_top dispatch_sva dispatch_sva_i (.*);

`default_nettype wire

//--- dispatch_tb.sv
`timescale 1ns/1ps
`default_nettype none

module dispatch_tb;
	import dispatch_pkg::*;

	logic                     clk;
	logic                     arst_n;
	logic                     disp_valid;
	logic [31:0]              instr;
	logic [XLEN-1:0]          pc;
	rf_read_t                 rf;
	logic                     flush;
	logic [N_ALU_RS-1:0]      alu_rs_busy;
	logic [N_AGU_RS-1:0]      agu_rs_busy;
	logic [N_BRANCH_RS-1:0]   branch_rs_busy;
	logic                     ldq_full;
	logic                     stq_full;
	cdb_t                     cdb;
	logic                     commit_ready;
	logic                     stall;
	logic [N_ALU_RS-1:0]      alu_rs_route;
	logic [N_AGU_RS-1:0]      agu_rs_route;
	logic [N_BRANCH_RS-1:0]   branch_rs_route;
	logic                     alloc_ldq;
	logic                     alloc_stq;
	issue_t                   issue;
	commit_t                  commit;
	logic [31:0]              lfsr;
	logic [31:0]              a;
	logic [31:0]              b;
	logic [31:0]              w;
	logic [31:0]              r;
	logic [31:0]              lui_val;

	clk_gen clk_gen_i (.clk(clk));

	dispatch_top dispatch_top_i (.*);

	task automatic fail_now(input string msg);
		$display("%s", msg);
		$display("SOME TESTS FAILED");
		$fatal(1);
	endtask

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic rand_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			v = {v[30:0], lfsr[0]};
		end
	endtask

	// encodings, rd x3 rs1 x1 rs2 x2
	function automatic logic [31:0] r_type();
		return {7'b0, 5'd2, 5'd1, 3'b0, 5'd3, 7'b0110011};
	endfunction

	function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [6:0] op);
		return {imm, 5'd1, 3'b0, 5'd3, op};
	endfunction

	function automatic logic [31:0] s_type(input logic [11:0] imm);
		return {imm[11:5], 5'd2, 5'd1, 3'b010, imm[4:0], 7'b0100011};
	endfunction

	function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [6:0] op);
		return {imm, 5'd3, op};
	endfunction

	function automatic logic [31:0] j_type(input logic [20:0] off);
		return {off[20], off[10:1], off[11], off[19:12], 5'd1, 7'b1101111};
	endfunction

	function automatic logic [31:0] sext12(input logic [11:0] imm);
		return {{20{imm[11]}}, imm};
	endfunction

	function automatic rf_read_t make_rf(input logic [31:0] v1, input logic [2:0] t1,
		input logic tv1, input logic [31:0] v2);
		return {v1, t1, tv1, v2, 3'd0, 1'b0};
	endfunction

	function automatic issue_t make_issue(input logic q1v, input logic [2:0] q1,
		input logic [31:0] v1, input logic [31:0] v2, input logic [2:0] tag);
		return {q1v, q1, v1, 1'b0, 3'd0, v2, tag};
	endfunction

	task automatic check_issue(input issue_t got, input issue_t exp);
		if (got !== exp)
			fail_now($sformatf("mismatch at %0t: issue got %h expected %h", $time, got, exp));
	endtask

	task automatic check_commit(input commit_t got, input commit_t exp);
		if (got !== exp)
			fail_now($sformatf("mismatch at %0t: commit got %h expected %h", $time, got, exp));
	endtask

	task automatic check_route(input string name, input logic [RS_VEC_WIDTH-1:0] got,
		input logic [RS_VEC_WIDTH-1:0] exp);
		if (got !== exp)
			fail_now($sformatf("mismatch at %0t: %s got %b expected %b", $time, name, got, exp));
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			fail_now($sformatf("mismatch at %0t: %s got %b expected %b", $time, name, got, exp));
	endtask

	// drive at the falling edge, outputs settle before the next rising edge
	task automatic present(input logic [31:0] ins, input logic [31:0] p, input rf_read_t rr);
		@(negedge clk);
		disp_valid = 1'b1;
		instr = ins;
		pc = p;
		rf = rr;
		#1;
	endtask

	task automatic dispatch(input logic [31:0] ins, input logic [31:0] p, input rf_read_t rr,
		input issue_t exp, input logic [3:0] ea, input logic [1:0] eg, input logic [1:0] eb);
		present(ins, p, rr);
		check_bit("stall", stall, 1'b0);
		check_route("alu_rs_route", RS_VEC_WIDTH'(alu_rs_route), RS_VEC_WIDTH'(ea));
		check_route("agu_rs_route", RS_VEC_WIDTH'(agu_rs_route), RS_VEC_WIDTH'(eg));
		check_route("branch_rs_route", RS_VEC_WIDTH'(branch_rs_route), RS_VEC_WIDTH'(eb));
		check_issue(issue, exp);
		// loads take an ldq slot, stores an stq slot
		check_bit("alloc_ldq", alloc_ldq, ins[6:0] == 7'b0000011);
		check_bit("alloc_stq", alloc_stq, ins[6:0] == 7'b0100011);
		@(negedge clk);
		disp_valid = 1'b0;
	endtask

	task automatic check_stalled();
		check_bit("stall", stall, 1'b1);
		check_route("alu_rs_route", RS_VEC_WIDTH'(alu_rs_route), '0);
		check_route("agu_rs_route", RS_VEC_WIDTH'(agu_rs_route), '0);
		check_route("branch_rs_route", RS_VEC_WIDTH'(branch_rs_route), '0);
		check_bit("alloc_ldq", alloc_ldq, 1'b0);
		check_bit("alloc_stq", alloc_stq, 1'b0);
	endtask

	task automatic cdb_write(input logic [2:0] tag, input logic [31:0] value);
		@(negedge clk);
		cdb = {1'b1, tag, value};
		@(negedge clk);
		cdb = '0;
	endtask

	task automatic wait_commit(input logic [2:0] tag, input logic [31:0] value);
		for (int i = 0; i < 50 && !commit.valid; i++)
			@(negedge clk);
		if (!commit.valid)
			fail_now("timeout waiting for commit.valid");
		check_commit(commit, {1'b1, tag, value});
		commit_ready = 1'b1;
		@(negedge clk);
		commit_ready = 1'b0;
	endtask

	// plain alu ops, station choice and in-order commit
	task automatic test_alu();
		logic [31:0] w1;
		rand_bits(32, a);
		rand_bits(32, b);
		rand_bits(12, r);
		alu_rs_busy = 4'b0001;
		dispatch(r_type(), 32'h100, make_rf(a, 0, 0, b), make_issue(0, 0, a, b, 0),
			4'b0010, 2'b0, 2'b0);
		alu_rs_busy = '0;
		dispatch(i_type(r[11:0], 7'b0010011), 32'h104, make_rf(a, 0, 0, b),
			make_issue(0, 0, a, sext12(r[11:0]), 1), 4'b0001, 2'b0, 2'b0);
		rand_bits(32, w);
		rand_bits(32, w1);
		cdb_write(0, w);
		cdb_write(1, w1);
		wait_commit(0, w);
		wait_commit(1, w1);
	endtask

	// entries that are complete at dispatch, jalr and store
	task automatic test_no_exec();
		logic [31:0] u;
		logic [31:0] j;
		rand_bits(20, u);
		rand_bits(20, j);
		rand_bits(12, r);
		dispatch(u_type(u[19:0], 7'b0110111), 32'h200, make_rf(a, 0, 0, b),
			make_issue(0, 0, 0, {u[19:0], 12'b0}, 2), 4'b0, 2'b0, 2'b0);
		dispatch(u_type(u[19:0], 7'b0010111), 32'h204, make_rf(a, 0, 0, b),
			make_issue(0, 0, 32'h204, {u[19:0], 12'b0}, 3), 4'b0, 2'b0, 2'b0);
		dispatch(j_type({j[19:0], 1'b0}), 32'h208, make_rf(a, 0, 0, b),
			make_issue(0, 0, 32'h208, {{11{j[19]}}, j[19:0], 1'b0}, 4), 4'b0, 2'b0, 2'b0);
		dispatch(i_type(r[11:0], 7'b1100111), 32'h20c, make_rf(a, 0, 0, b),
			make_issue(0, 0, a, sext12(r[11:0]), 5), 4'b0, 2'b0, 2'b01);
		dispatch(s_type(r[11:0]), 32'h210, make_rf(a, 0, 0, b),
			make_issue(0, 0, a, sext12(r[11:0]), 6), 4'b0, 2'b01, 2'b0);
		wait_commit(2, {u[19:0], 12'b0});
		wait_commit(3, 32'h204 + {u[19:0], 12'b0});
		wait_commit(4, 32'h20c);
		rand_bits(32, w);
		cdb_write(5, w);
		wait_commit(5, w);
		wait_commit(6, b);
	endtask

	// tag first, forwarded value one cycle after the cdb write
	task automatic test_forward();
		dispatch(i_type(12'h001, 7'b0010011), 32'h300, make_rf(a, 0, 0, b),
			make_issue(0, 0, a, 1, 7), 4'b0001, 2'b0, 2'b0);
		dispatch(r_type(), 32'h304, make_rf(a, 7, 1, b), make_issue(1, 7, 0, b, 0),
			4'b0001, 2'b0, 2'b0);
		rand_bits(32, w);
		cdb_write(7, w);
		dispatch(r_type(), 32'h308, make_rf(a, 7, 1, b), make_issue(0, 0, w, b, 1),
			4'b0001, 2'b0, 2'b0);
	endtask

	task automatic test_flush();
		flush = 1'b1;
		present(i_type(12'h004, 7'b0000011), 32'h400, make_rf(a, 0, 0, b));
		check_route("agu_rs_route", RS_VEC_WIDTH'(agu_rs_route), '0);
		check_bit("alloc_ldq", alloc_ldq, 1'b0);
		@(negedge clk);
		flush = 1'b0;
		disp_valid = 1'b0;
		#1;
		check_bit("commit.valid", commit.valid, 1'b0);
		rand_bits(20, r);
		lui_val = {r[19:0], 12'b0};
		dispatch(u_type(r[19:0], 7'b0110111), 32'h404, make_rf(a, 0, 0, b),
			make_issue(0, 0, 0, lui_val, 0), 4'b0, 2'b0, 2'b0);
	endtask

	task automatic test_backpressure();
		alu_rs_busy = '1;
		present(r_type(), 32'h500, make_rf(a, 0, 0, b));
		check_stalled();
		@(negedge clk);
		disp_valid = 1'b0;
		alu_rs_busy = '0;
		dispatch(r_type(), 32'h500, make_rf(a, 0, 0, b), make_issue(0, 0, a, b, 1),
			4'b0001, 2'b0, 2'b0);
		ldq_full = 1'b1;
		present(i_type(12'h008, 7'b0000011), 32'h504, make_rf(a, 0, 0, b));
		check_stalled();
		@(negedge clk);
		disp_valid = 1'b0;
		ldq_full = 1'b0;
		dispatch(i_type(12'h008, 7'b0000011), 32'h504, make_rf(a, 0, 0, b),
			make_issue(0, 0, a, 8, 2), 4'b0, 2'b01, 2'b0);
		// fill the rest of the rob with commit_ready low
		for (int k = 3; k < ROB_SIZE; k++)
			dispatch(u_type(20'h1, 7'b0110111), 32'h508, make_rf(a, 0, 0, b),
				make_issue(0, 0, 0, 32'h1000, 3'(k)), 4'b0, 2'b0, 2'b0);
		present(u_type(20'h2, 7'b0110111), 32'h50c, make_rf(a, 0, 0, b));
		check_stalled();
		@(negedge clk);
		disp_valid = 1'b0;
		wait_commit(0, lui_val);
		dispatch(u_type(20'h2, 7'b0110111), 32'h50c, make_rf(a, 0, 0, b),
			make_issue(0, 0, 0, 32'h2000, 0), 4'b0, 2'b0, 2'b0);
	endtask

	initial begin
		#200000;
		fail_now("simulation timeout");
	end

	initial begin
		lfsr = 32'h6fbf_74db;
		arst_n = 1'b0;
		disp_valid = 1'b0;
		instr = '0;
		pc = '0;
		rf = '0;
		flush = 1'b0;
		alu_rs_busy = '0;
		agu_rs_busy = '0;
		branch_rs_busy = '0;
		ldq_full = 1'b0;
		stq_full = 1'b0;
		cdb = '0;
		commit_ready = 1'b0;
		lui_val = '0;
		repeat (16) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
		test_alu();
		test_no_exec();
		test_forward();
		test_flush();
		test_backpressure();
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- dispatch_top.sv
`timescale 1ns/1ps
`default_nettype none

module dispatch_top (
	input  logic                                clk,
	input  logic                                arst_n,
	input  logic                                disp_valid,
	input  logic [31:0]                         instr,
	input  logic [dispatch_pkg::XLEN-1:0]        pc,
	input  dispatch_pkg::rf_read_t              rf,
	input  logic                                flush,
	input  logic [dispatch_pkg::N_ALU_RS-1:0]    alu_rs_busy,
	input  logic [dispatch_pkg::N_AGU_RS-1:0]    agu_rs_busy,
	input  logic [dispatch_pkg::N_BRANCH_RS-1:0] branch_rs_busy,
	input  logic                                ldq_full,
	input  logic                                stq_full,
	input  dispatch_pkg::cdb_t                  cdb,
	input  logic                                commit_ready,
	output logic                                stall,
	output logic [dispatch_pkg::N_ALU_RS-1:0]    alu_rs_route,
	output logic [dispatch_pkg::N_AGU_RS-1:0]    agu_rs_route,
	output logic [dispatch_pkg::N_BRANCH_RS-1:0] branch_rs_route,
	output logic                                alloc_ldq,
	output logic                                alloc_stq,
	output dispatch_pkg::issue_t                issue,
	output dispatch_pkg::commit_t               commit
);
	import dispatch_pkg::*;

	decoded_t                      dec;
	operands_t                     ops;
	logic                          alloc_rob;
	logic                          rob_full;
	logic [ROB_TAG_WIDTH-1:0]      tail_tag;
	logic [ROB_SIZE-1:0][XLEN-1:0] rob_value;
	logic [ROB_SIZE-1:0]           rob_ready;
	logic [XLEN-1:0]               init_value;
	logic                          init_ready;

	rv_decode rv_decode_i (
		.instr (instr),
		.dec   (dec)
	);

	issue_route issue_route_i (
		.disp_valid      (disp_valid),
		.flush           (flush),
		.dec             (dec),
		.rob_full        (rob_full),
		.ldq_full        (ldq_full),
		.stq_full        (stq_full),
		.alu_rs_busy     (alu_rs_busy),
		.agu_rs_busy     (agu_rs_busy),
		.branch_rs_busy  (branch_rs_busy),
		.alu_rs_route    (alu_rs_route),
		.agu_rs_route    (agu_rs_route),
		.branch_rs_route (branch_rs_route),
		.alloc_rob       (alloc_rob),
		.alloc_ldq       (alloc_ldq),
		.alloc_stq       (alloc_stq),
		.stall           (stall)
	);

	// forwarding reads registered rob state, no same-cycle cdb bypass
	operand_route operand_route_i (
		.dec       (dec),
		.pc        (pc),
		.rf        (rf),
		.rob_value (rob_value),
		.rob_ready (rob_ready),
		.ops       (ops)
	);

	rob_entry_init rob_entry_init_i (
		.dec   (dec),
		.pc    (pc),
		.rf    (rf),
		.value (init_value),
		.ready (init_ready)
	);

	reorder_buffer reorder_buffer_i (
		.clk          (clk),
		.arst_n       (arst_n),
		.flush        (flush),
		.alloc        (alloc_rob),
		.alloc_value  (init_value),
		.alloc_ready  (init_ready),
		.cdb          (cdb),
		.commit_ready (commit_ready),
		.tail_tag     (tail_tag),
		.rob_full     (rob_full),
		.rob_value    (rob_value),
		.rob_ready    (rob_ready),
		.commit       (commit)
	);

	// station record, the destination is the entry being allocated now
	assign issue.q1_valid = ops.op1.q_valid;
	assign issue.q1 = ops.op1.q;
	assign issue.v1 = ops.op1.v;
	assign issue.q2_valid = ops.op2.q_valid;
	assign issue.q2 = ops.op2.q;
	assign issue.v2 = ops.op2.v;
	assign issue.rob_tag = tail_tag;

endmodule

`default_nettype wire

//--- files.f
dispatch_pkg.sv
rv_decode.sv
issue_route.sv
operand_route.sv
rob_entry_init.sv
reorder_buffer.sv
dispatch_top.sv
clk_gen.sv
dispatch_sva.sv
dispatch_tb.sv

//--- issue_route.sv
`timescale 1ns/1ps
`default_nettype none

module issue_route (
	input  logic                                disp_valid,
	input  logic                                flush,
	input  dispatch_pkg::decoded_t              dec,
	input  logic                                rob_full,
	input  logic                                ldq_full,
	input  logic                                stq_full,
	input  logic [dispatch_pkg::N_ALU_RS-1:0]    alu_rs_busy,
	input  logic [dispatch_pkg::N_AGU_RS-1:0]    agu_rs_busy,
	input  logic [dispatch_pkg::N_BRANCH_RS-1:0] branch_rs_busy,
	output logic [dispatch_pkg::N_ALU_RS-1:0]    alu_rs_route,
	output logic [dispatch_pkg::N_AGU_RS-1:0]    agu_rs_route,
	output logic [dispatch_pkg::N_BRANCH_RS-1:0] branch_rs_route,
	output logic                                alloc_rob,
	output logic                                alloc_ldq,
	output logic                                alloc_stq,
	output logic                                stall
);
	import dispatch_pkg::*;

	logic                    to_alu;
	logic                    to_agu;
	logic                    to_branch;
	logic [RS_VEC_WIDTH-1:0] alu_busy_pad;
	logic [RS_VEC_WIDTH-1:0] agu_busy_pad;
	logic [RS_VEC_WIDTH-1:0] branch_busy_pad;
	logic [RS_VEC_WIDTH-1:0] alu_sel;
	logic [RS_VEC_WIDTH-1:0] agu_sel;
	logic [RS_VEC_WIDTH-1:0] branch_sel;
	logic                    need_stall;
	logic                    go;

	// lui and auipc already have their value, nothing to execute
	assign to_alu = (dec.instr_class == CLASS_ALU) && (dec.opcode != OP_BUBBLE)
		&& !dec.lui && !dec.auipc;
	// loads and stores both need address generation
	assign to_agu = dec.instr_class[1];
	// jal is resolved at dispatch, only jalr and branches execute
	assign to_branch = (dec.instr_class == CLASS_BRANCH) && (dec.branch || dec.jalr);

	// pad narrower classes with busy ones so the shared selector skips them
	always_comb begin
		alu_busy_pad = '1;
		agu_busy_pad = '1;
		branch_busy_pad = '1;
		alu_busy_pad[N_ALU_RS-1:0] = alu_rs_busy;
		agu_busy_pad[N_AGU_RS-1:0] = agu_rs_busy;
		branch_busy_pad[N_BRANCH_RS-1:0] = branch_rs_busy;
	end

	assign alu_sel = lowest_free(alu_busy_pad);
	assign agu_sel = lowest_free(agu_busy_pad);
	assign branch_sel = lowest_free(branch_busy_pad);

	// any missing resource holds the instruction
	assign need_stall = (dec.alloc_rob && rob_full)
		|| (dec.alloc_ldq && ldq_full)
		|| (dec.alloc_stq && stq_full)
		|| (to_alu && (&alu_rs_busy))
		|| (to_agu && (&agu_rs_busy))
		|| (to_branch && (&branch_rs_busy));

	// valid and flush only enter at the end of the chain
	assign go = disp_valid && !flush && !need_stall;
	assign stall = disp_valid && need_stall;

	assign alu_rs_route = alu_sel[N_ALU_RS-1:0] & {N_ALU_RS{to_alu && go}};
	assign agu_rs_route = agu_sel[N_AGU_RS-1:0] & {N_AGU_RS{to_agu && go}};
	assign branch_rs_route = branch_sel[N_BRANCH_RS-1:0] & {N_BRANCH_RS{to_branch && go}};

	assign alloc_rob = go && dec.alloc_rob;
	assign alloc_ldq = go && dec.alloc_ldq;
	assign alloc_stq = go && dec.alloc_stq;

endmodule

`default_nettype wire

//--- operand_route.sv
`timescale 1ns/1ps
`default_nettype none

module operand_route (
	input  dispatch_pkg::decoded_t                                  dec,
	input  logic [dispatch_pkg::XLEN-1:0]                           pc,
	input  dispatch_pkg::rf_read_t                                  rf,
	input  logic [dispatch_pkg::ROB_SIZE-1:0][dispatch_pkg::XLEN-1:0] rob_value,
	input  logic [dispatch_pkg::ROB_SIZE-1:0]                       rob_ready,
	output dispatch_pkg::operands_t                                 ops
);
	import dispatch_pkg::*;

	operand_t rs1_op;
	operand_t rs2_op;

	// register operand: rf value, forwarded rob value, or a tag to wait on
	function automatic operand_t resolve_reg(
		input logic                              tag_valid,
		input logic [ROB_TAG_WIDTH-1:0]          tag,
		input logic [XLEN-1:0]                   rf_value,
		input logic [ROB_SIZE-1:0]               ready,
		input logic [ROB_SIZE-1:0][XLEN-1:0]     values
	);
		operand_t op;
		op = '0;
		if (!tag_valid) begin
			op.v = rf_value;
		end else if (ready[tag]) begin
			// producer finished but has not committed yet
			op.v = values[tag];
		end else begin
			op.q_valid = 1'b1;
			op.q = tag;
		end
		return op;
	endfunction

	assign rs1_op = resolve_reg(rf.rs1_tag_valid, rf.rs1_tag, rf.rs1_value, rob_ready, rob_value);
	assign rs2_op = resolve_reg(rf.rs2_tag_valid, rf.rs2_tag, rf.rs2_value, rob_ready, rob_value);

	// operand 1
	always_comb begin
		ops.op1 = '0;
		case (dec.opcode)
			OP_JAL, OP_AUIPC: ops.op1.v = pc;
			// lui carries its value in the immediate, bubble carries nothing
			OP_LUI, OP_BUBBLE: ops.op1 = '0;
			default: ops.op1 = rs1_op;
		endcase
	end

	// operand 2
	always_comb begin
		ops.op2 = '0;
		case (dec.opcode)
			OP_REG, OP_BRANCH: ops.op2 = rs2_op;
			// immediate is zero for the bubble
			default: ops.op2.v = dec.imm;
		endcase
	end

endmodule

`default_nettype wire

//--- reorder_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module reorder_buffer (
	input  logic                                                     clk,
	input  logic                                                     arst_n,
	input  logic                                                     flush,
	input  logic                                                     alloc,
	input  logic [dispatch_pkg::XLEN-1:0]                            alloc_value,
	input  logic                                                     alloc_ready,
	input  dispatch_pkg::cdb_t                                       cdb,
	input  logic                                                     commit_ready,
	output logic [dispatch_pkg::ROB_TAG_WIDTH-1:0]                   tail_tag,
	output logic                                                     rob_full,
	output logic [dispatch_pkg::ROB_SIZE-1:0][dispatch_pkg::XLEN-1:0] rob_value,
	output logic [dispatch_pkg::ROB_SIZE-1:0]                        rob_ready,
	output dispatch_pkg::commit_t                                    commit
);
	import dispatch_pkg::*;

	logic [ROB_TAG_WIDTH-1:0]      head;
	logic [ROB_TAG_WIDTH-1:0]      tail;
	logic [ROB_TAG_WIDTH:0]        count;
	logic [ROB_SIZE-1:0]           occupied;
	logic [ROB_SIZE-1:0]           ready;
	logic [ROB_SIZE-1:0][XLEN-1:0] value;
	logic                          do_commit;
	logic                          cdb_hit;

	assign tail_tag = tail;
	assign rob_full = (count == (ROB_TAG_WIDTH + 1)'(ROB_SIZE));
	assign rob_value = value;
	assign rob_ready = ready;

	// head retires once its result is in
	assign commit.valid = occupied[head] && ready[head];
	assign commit.tag = head;
	assign commit.value = value[head];
	assign do_commit = commit.valid && commit_ready;

	// results for entries already gone are dropped
	assign cdb_hit = cdb.valid && occupied[cdb.tag];

	// control state, pointers wrap since ROB_SIZE is a power of two
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			head <= '0;
			tail <= '0;
			count <= '0;
			occupied <= '0;
			ready <= '0;
		end else if (flush) begin
			head <= '0;
			tail <= '0;
			count <= '0;
			occupied <= '0;
			ready <= '0;
		end else begin
			if (cdb_hit) begin
				ready[cdb.tag] <= 1'b1;
			end
			if (alloc) begin
				occupied[tail] <= 1'b1;
				ready[tail] <= alloc_ready;
				tail <= tail + 1'b1;
			end
			// head and tail only meet here when empty or full, so no clash
			if (do_commit) begin
				occupied[head] <= 1'b0;
				ready[head] <= 1'b0;
				head <= head + 1'b1;
			end
			case ({alloc, do_commit})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// result payload
	always_ff @(posedge clk) begin
		if (cdb_hit) begin
			value[cdb.tag] <= cdb.value;
		end
		if (alloc) begin
			value[tail] <= alloc_value;
		end
	end

endmodule

`default_nettype wire

//--- rob_entry_init.sv
`timescale 1ns/1ps
`default_nettype none

module rob_entry_init (
	input  dispatch_pkg::decoded_t        dec,
	input  logic [dispatch_pkg::XLEN-1:0] pc,
	input  dispatch_pkg::rf_read_t        rf,
	output logic [dispatch_pkg::XLEN-1:0] value,
	output logic                          ready
);
	import dispatch_pkg::*;

	logic            is_jal;
	logic            is_jump;
	logic            store_ready;
	logic [XLEN-1:0] next_pc;

	// no compressed instructions
	assign next_pc = pc + XLEN'(4);

	assign is_jump = (dec.instr_class == CLASS_BRANCH) && !dec.branch;
	assign is_jal = is_jump && !dec.jalr;
	assign store_ready = (dec.instr_class == CLASS_STORE) && !rf.rs2_tag_valid;

	// jalr still has to execute for its target, so it starts not ready
	assign ready = is_jal || dec.lui || dec.auipc || store_ready;

	always_comb begin
		if (is_jump) begin
			// link value for jal and jalr
			value = next_pc;
		end else if (dec.lui) begin
			value = dec.imm;
		end else if (dec.auipc) begin
			value = pc + dec.imm;
		end else if (store_ready) begin
			value = rf.rs2_value;
		end else begin
			value = '0;
		end
	end

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# builds with Verilator and runs, exit status follows the testbench
verilator --binary --timing --assert --top-module dispatch_tb -f files.f -o dispatch_sim \
	&& ./obj_dir/dispatch_sim \
	|| exit 1

//--- rv_decode.sv
`timescale 1ns/1ps
`default_nettype none

module rv_decode (
	input  logic [31:0]           instr,
	output dispatch_pkg::decoded_t dec
);
	import dispatch_pkg::*;

	opcode_e         raw_op;
	logic [XLEN-1:0] imm_i;
	logic [XLEN-1:0] imm_s;
	logic [XLEN-1:0] imm_b;
	logic [XLEN-1:0] imm_u;
	logic [XLEN-1:0] imm_j;

	assign raw_op = opcode_e'(instr[6:0]);

	// immediates for every format, picked by opcode below
	assign imm_i = {{20{instr[31]}}, instr[31:20]};
	assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign imm_u = {instr[31:12], 12'b0};
	assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

	always_comb begin
		// unknown opcodes fall through as a bubble
		dec = '0;
		case (raw_op)
			OP_REG: begin
				// r-type has no immediate
				dec.opcode = OP_REG;
			end
			OP_IMM: begin
				dec.opcode = OP_IMM;
				dec.imm = imm_i;
			end
			OP_LOAD: begin
				dec.opcode = OP_LOAD;
				dec.instr_class = CLASS_LOAD;
				dec.alloc_ldq = 1'b1;
				dec.imm = imm_i;
			end
			OP_STORE: begin
				dec.opcode = OP_STORE;
				dec.instr_class = CLASS_STORE;
				dec.alloc_stq = 1'b1;
				dec.imm = imm_s;
			end
			OP_BRANCH: begin
				dec.opcode = OP_BRANCH;
				dec.instr_class = CLASS_BRANCH;
				dec.branch = 1'b1;
				dec.imm = imm_b;
			end
			OP_JALR: begin
				dec.opcode = OP_JALR;
				dec.instr_class = CLASS_BRANCH;
				dec.jalr = 1'b1;
				dec.imm = imm_i;
			end
			OP_JAL: begin
				// branch class with neither flag set means jal
				dec.opcode = OP_JAL;
				dec.instr_class = CLASS_BRANCH;
				dec.imm = imm_j;
			end
			OP_LUI: begin
				dec.opcode = OP_LUI;
				dec.lui = 1'b1;
				dec.imm = imm_u;
			end
			OP_AUIPC: begin
				dec.opcode = OP_AUIPC;
				dec.auipc = 1'b1;
				dec.imm = imm_u;
			end
			default: begin
			end
		endcase
		// every real instruction takes a rob entry, bubbles take nothing
		dec.alloc_rob = (dec.opcode != OP_BUBBLE);
	end

endmodule

`default_nettype wire
